// ==== src/exu_pkg.sv ====
package exu_pkg;

  // datapath and memory sizes
  localparam int XLEN       = 32;
  localparam int CSR_ADDR_W = 12;
  localparam int DMEM_WORDS = 64;
  localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);

  // machine csr addresses
  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;

  // environment call from m-mode
  localparam logic [XLEN-1:0] CAUSE_ECALL_M = 32'd11;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR,
    SLL, SRL, SRA,
    SLT, SLTU, SLE, SLEU
  } alu_op_e;

  typedef enum logic [2:0] {
    ALU, BRANCH, JUMP, LOAD, STORE, CSR, ECALL, MRET
  } op_kind_e;

  // immediate forms carry the zero-extended uimm in op1
  typedef enum logic [1:0] {
    RW, RS, RC
  } csr_op_e;

  // decoded operation, csr address sits in imm[11:0]
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] opj;
    logic [4:0]      rd;
    op_kind_e        kind;
    alu_op_e         alu_op;
    csr_op_e         csr_op;
    logic            ebreak;
  } exu_issue_t;

  // retired record
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rd_wdata;
    logic [XLEN-1:0] npc;
    logic [4:0]      rd;
    logic            redirect;
    logic            ebreak;
  } exu_result_t;

  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            we;
  } dmem_req_t;

endpackage

// ==== src/exu_alu.sv ====
`timescale 1ns/1ns

module exu_alu (
  input  logic [exu_pkg::XLEN-1:0] a_i,
  input  logic [exu_pkg::XLEN-1:0] b_i,
  input  exu_pkg::alu_op_e         op_i,
  output logic [exu_pkg::XLEN-1:0] res_o
);
  import exu_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = b_i[4:0];
  assign lt_s  = $signed(a_i) < $signed(b_i);
  assign lt_u  = a_i < b_i;
  assign eq    = a_i == b_i;

  always_comb begin
    case (op_i)
      ADD:  res_o = a_i + b_i;
      SUB:  res_o = a_i - b_i;
      AND:  res_o = a_i & b_i;
      OR:   res_o = a_i | b_i;
      XOR:  res_o = a_i ^ b_i;
      SLL:  res_o = a_i << shamt;
      SRL:  res_o = a_i >> shamt;
      // arithmetic shift keeps the sign bit
      SRA:  res_o = $signed(a_i) >>> shamt;
      // compares give 0 or 1
      SLT:  res_o = XLEN'(lt_s);
      SLTU: res_o = XLEN'(lt_u);
      SLE:  res_o = XLEN'(lt_s | eq);
      SLEU: res_o = XLEN'(lt_u | eq);
      default: begin
        res_o = '0;
      end
    endcase
  end

endmodule

// ==== src/exu_csr.sv ====
`timescale 1ns/1ns

module exu_csr (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [exu_pkg::CSR_ADDR_W-1:0] addr_i,
  input  exu_pkg::csr_op_e               op_i,
  input  logic [exu_pkg::XLEN-1:0]       src_i,
  input  exu_pkg::op_kind_e              kind_i,
  input  logic [exu_pkg::XLEN-1:0]       pc_i,
  input  logic                           commit_i,
  output logic [exu_pkg::XLEN-1:0]       rdata_o,
  output logic [exu_pkg::XLEN-1:0]       mtvec_o,
  output logic [exu_pkg::XLEN-1:0]       mepc_o
);
  import exu_pkg::*;

  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;
  logic [XLEN-1:0] wdata;

  // read side, unmapped addresses give zero
  always_comb begin
    case (addr_i)
      CSR_MSTATUS: rdata_o = mstatus_q;
      CSR_MTVEC:   rdata_o = mtvec_q;
      CSR_MEPC:    rdata_o = mepc_q;
      CSR_MCAUSE:  rdata_o = mcause_q;
      default:     rdata_o = '0;
    endcase
  end

  // read-modify-write value
  always_comb begin
    case (op_i)
      RW:      wdata = src_i;
      RS:      wdata = rdata_o | src_i;
      RC:      wdata = rdata_o & ~src_i;
      default: wdata = rdata_o;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (commit_i) begin
      case (kind_i)
        CSR: begin
          case (addr_i)
            CSR_MSTATUS: mstatus_q <= wdata;
            CSR_MTVEC:   mtvec_q   <= wdata;
            CSR_MEPC:    mepc_q    <= wdata;
            CSR_MCAUSE:  mcause_q  <= wdata;
            default: ;
          endcase
        end
        ECALL: begin
          mepc_q   <= pc_i;
          mcause_q <= CAUSE_ECALL_M;
        end
        MRET: begin
          // mpie back into mie, mpie set
          mstatus_q[3] <= mstatus_q[7];
          mstatus_q[7] <= 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  // stage must hand over a defined kind with every commit
  a_commit_kind_known: assert property (
    @(posedge clk) disable iff (rst) commit_i |-> !$isunknown(kind_i)
  );

endmodule

// ==== src/exu_stage.sv ====
`timescale 1ns/1ns

module exu_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  exu_pkg::exu_issue_t      issue_i,
  input  logic                     issue_valid_i,
  output logic                     issue_ready_o,
  output exu_pkg::exu_result_t     result_o,
  output logic                     result_valid_o,
  input  logic                     result_ready_i,
  output exu_pkg::dmem_req_t       mem_req_o,
  output logic                     mem_valid_o,
  input  logic                     mem_ack_i,
  input  logic [exu_pkg::XLEN-1:0] mem_rdata_i
);
  import exu_pkg::*;

  exu_issue_t      op_q;
  logic [XLEN-1:0] ld_data_q;
  logic            busy_q;
  logic            res_valid_q;
  logic            mem_valid_q;

  logic            issue_fire;
  logic            commit;
  logic            mem_done;
  logic            issue_is_mem;

  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] csr_rdata;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic            redirect;

  assign commit        = res_valid_q & result_ready_i;
  // accept when empty or when the held result leaves this cycle
  assign issue_ready_o = ~busy_q | commit;
  assign issue_fire    = issue_valid_i & issue_ready_o;
  assign mem_done      = mem_valid_q & mem_ack_i;
  assign issue_is_mem  = (issue_i.kind == LOAD) | (issue_i.kind == STORE);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q      <= 1'b0;
      res_valid_q <= 1'b0;
      mem_valid_q <= 1'b0;
    end else begin
      if (commit) begin
        busy_q      <= 1'b0;
        res_valid_q <= 1'b0;
      end
      if (mem_done) begin
        mem_valid_q <= 1'b0;
        res_valid_q <= 1'b1;
      end
      // a new issue overrides the clear from commit
      if (issue_fire) begin
        busy_q <= 1'b1;
        if (issue_is_mem) begin
          mem_valid_q <= 1'b1;
        end else begin
          res_valid_q <= 1'b1;
        end
      end
    end
  end

  // operand and load data latches
  always_ff @(posedge clk) begin
    if (issue_fire) begin
      op_q <= issue_i;
    end
    if (mem_done) begin
      ld_data_q <= mem_rdata_i;
    end
  end

  exu_alu alu0 (
    .a_i  (op_q.op1),
    .b_i  (op_q.op2),
    .op_i (op_q.alu_op),
    .res_o(alu_res)
  );

  // csr writes land only on the result transfer
  exu_csr csr0 (
    .clk     (clk),
    .rst     (rst),
    .addr_i  (op_q.imm[CSR_ADDR_W-1:0]),
    .op_i    (op_q.csr_op),
    .src_i   (op_q.op1),
    .kind_i  (op_q.kind),
    .pc_i    (op_q.pc),
    .commit_i(commit),
    .rdata_o (csr_rdata),
    .mtvec_o (mtvec),
    .mepc_o  (mepc)
  );

  assign target   = op_q.opj + op_q.imm;
  assign pc_plus4 = op_q.pc + XLEN'(4);

  // beq is a sub that gives zero, other branch compares taken on non-zero
  always_comb begin
    case (op_q.kind)
      JUMP, ECALL, MRET: redirect = 1'b1;
      BRANCH:            redirect = (op_q.alu_op == SUB) ? ~|alu_res : |alu_res;
      default:           redirect = 1'b0;
    endcase
  end

  always_comb begin
    result_o.pc       = op_q.pc;
    result_o.rd       = op_q.rd;
    result_o.redirect = redirect;
    result_o.ebreak   = op_q.ebreak;

    if (op_q.kind == ECALL) begin
      result_o.npc = mtvec;
    end else if (op_q.kind == MRET) begin
      result_o.npc = mepc;
    end else if (redirect) begin
      result_o.npc = target;
    end else begin
      result_o.npc = pc_plus4;
    end

    if (op_q.rd == 5'd0) begin
      result_o.rd_wdata = '0;
    end else begin
      case (op_q.kind)
        LOAD:    result_o.rd_wdata = ld_data_q;
        CSR:     result_o.rd_wdata = csr_rdata;
        JUMP:    result_o.rd_wdata = pc_plus4;
        default: result_o.rd_wdata = alu_res;
      endcase
    end
  end

  assign result_valid_o  = res_valid_q;
  assign mem_valid_o     = mem_valid_q;
  assign mem_req_o.addr  = target;
  assign mem_req_o.wdata = op_q.op2;
  assign mem_req_o.we    = op_q.kind == STORE;

  a_no_issue_during_mem: assert property (
    @(posedge clk) disable iff (rst) mem_valid_o |-> !issue_ready_o
  );

  // held result must not move while the consumer stalls
  a_result_stable: assert property (
    @(posedge clk) disable iff (rst)
    result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_o)
  );

endmodule

// ==== src/exu_dmem.sv ====
`timescale 1ns/1ns

module exu_dmem (
  input  logic                     clk,
  input  logic                     rst,
  input  exu_pkg::dmem_req_t       req_i,
  input  logic                     valid_i,
  output logic                     ack_o,
  output logic [exu_pkg::XLEN-1:0] rdata_o
);
  import exu_pkg::*;

  logic [XLEN-1:0]       mem_q [DMEM_WORDS];
  logic [XLEN-1:0]       rdata_q;
  logic                  ack_q;
  logic                  take;
  logic [DMEM_IDX_W-1:0] idx;

  // one request at a time, the held request is ignored while acking
  assign take = valid_i & ~ack_q;
  assign idx  = req_i.addr[DMEM_IDX_W+1:2];

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
      for (int i = 0; i < DMEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      ack_q <= take;
      if (take && req_i.we) begin
        mem_q[idx] <= req_i.wdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rdata_q <= mem_q[idx];
    end
  end

  assign ack_o   = ack_q;
  assign rdata_o = rdata_q;

  a_word_aligned: assert property (
    @(posedge clk) disable iff (rst) valid_i |-> req_i.addr[1:0] == 2'b00
  );

endmodule

// ==== src/exu_top.sv ====
`timescale 1ns/1ns

module exu_top (
  input  logic                 clk,
  input  logic                 rst,
  input  exu_pkg::exu_issue_t  issue_i,
  input  logic                 issue_valid_i,
  output logic                 issue_ready_o,
  output exu_pkg::exu_result_t result_o,
  output logic                 result_valid_o,
  input  logic                 result_ready_i
);
  import exu_pkg::*;

  // stage to data memory
  dmem_req_t       mem_req;
  logic            mem_valid;
  logic            mem_ack;
  logic [XLEN-1:0] mem_rdata;

  exu_stage stage0 (
    .clk           (clk),
    .rst           (rst),
    .issue_i       (issue_i),
    .issue_valid_i (issue_valid_i),
    .issue_ready_o (issue_ready_o),
    .result_o      (result_o),
    .result_valid_o(result_valid_o),
    .result_ready_i(result_ready_i),
    .mem_req_o     (mem_req),
    .mem_valid_o   (mem_valid),
    .mem_ack_i     (mem_ack),
    .mem_rdata_i   (mem_rdata)
  );

  exu_dmem dmem0 (
    .clk    (clk),
    .rst    (rst),
    .req_i  (mem_req),
    .valid_i(mem_valid),
    .ack_o  (mem_ack),
    .rdata_o(mem_rdata)
  );

endmodule

// ==== dv/exu_tb.sv ====
`timescale 1ns/1ns

module exu_tb;
  import exu_pkg::*;

  logic        clk;
  logic        rst;
  exu_issue_t  issue_i;
  logic        issue_valid_i;
  logic        issue_ready_o;
  exu_result_t result_o;
  logic        result_valid_o;
  logic        result_ready_i;

  exu_issue_t  ops [$];
  exu_result_t exp_res [$];
  integer      seed;

  exu_top dut0 (
    .clk           (clk),
    .rst           (rst),
    .issue_i       (issue_i),
    .issue_valid_i (issue_valid_i),
    .issue_ready_o (issue_ready_o),
    .result_o      (result_o),
    .result_valid_o(result_valid_o),
    .result_ready_i(result_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string field, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, field, got, exp);
      $display("tests failed");
      $fatal(1, "result mismatch");
    end
  endtask

  // issue fields first and the expected result fields after them
  task automatic load_trace();
    integer      fd;
    integer      n;
    string       line;
    logic [31:0] c [16];
    exu_issue_t  op;
    exu_result_t r;
    fd = $fopen("dv/exu_trace.txt", "r");
    if (fd == 0) begin
      fail_now("could not open the trace file dv/exu_trace.txt");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7],
                    c[8], c[9], c[10], c[11], c[12], c[13], c[14], c[15]);
        if (n != 16) begin
          fail_now("a line of the trace file does not hold 16 fields");
        end
        op.kind     = op_kind_e'(c[0][2:0]);
        op.alu_op   = alu_op_e'(c[1][3:0]);
        op.csr_op   = csr_op_e'(c[2][1:0]);
        op.pc       = c[3];
        op.op1      = c[4];
        op.op2      = c[5];
        op.imm      = c[6];
        op.opj      = c[7];
        op.rd       = c[8][4:0];
        op.ebreak   = c[9][0];
        r.pc        = c[10];
        r.rd        = c[11][4:0];
        r.rd_wdata  = c[12];
        r.npc       = c[13];
        r.redirect  = c[14][0];
        r.ebreak    = c[15][0];
        ops.push_back(op);
        exp_res.push_back(r);
      end
    end
    $fclose(fd);
  endtask

  // starts 1 ns after a rising edge and returns 1 ns after the transfer edge
  task automatic send_op(input exu_issue_t op);
    int waited;
    issue_i       = op;
    issue_valid_i = 1'b1;
    waited        = 0;
    @(negedge clk);
    while (!issue_ready_o) begin
      waited++;
      if (waited > 50) begin
        fail_now("timeout: the stage did not accept an operation within 50 cycles");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic send_all();
    foreach (ops[i]) begin
      send_op(ops[i]);
    end
    issue_valid_i = 1'b0;
  endtask

  // random stalls on the result side with each transfer checked in order
  task automatic collect_results();
    int          idx;
    int          waited;
    exu_result_t exp;
    idx    = 0;
    waited = 0;
    while (idx < exp_res.size()) begin
      @(posedge clk);
      #1;
      result_ready_i = ($random(seed) & 3) != 0;
      @(negedge clk);
      if (result_valid_o && result_ready_i) begin
        exp = exp_res[idx];
        check_val("pc", result_o.pc, exp.pc);
        check_val("rd", 32'(result_o.rd), 32'(exp.rd));
        check_val("rd_wdata", result_o.rd_wdata, exp.rd_wdata);
        check_val("npc", result_o.npc, exp.npc);
        check_val("redirect", 32'(result_o.redirect), 32'(exp.redirect));
        check_val("ebreak", 32'(result_o.ebreak), 32'(exp.ebreak));
        idx++;
        waited = 0;
      end else begin
        waited++;
        if (waited > 50) begin
          fail_now("timeout: no result transferred within 50 cycles");
        end
      end
    end
    @(posedge clk);
    #1;
    result_ready_i = 1'b0;
  endtask

  initial begin
    seed           = 32'h20de_f8a2;
    rst            = 1'b1;
    issue_i        = '0;
    issue_valid_i  = 1'b0;
    result_ready_i = 1'b0;
    load_trace();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_val("issue_ready after reset", 32'(issue_ready_o), 32'd1);
    check_val("result_valid after reset", 32'(result_valid_o), 32'd0);
    @(posedge clk);
    #1;
    fork
      send_all();
      collect_results();
    join
    // nothing may retire twice
    repeat (5) @(negedge clk);
    check_val("result_valid after last op", 32'(result_valid_o), 32'd0);
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== dv/exu_trace.txt ====
# kind alu csr pc op1 op2 imm opj rd ebreak exp_pc exp_rd exp_wdata exp_npc exp_redirect exp_ebreak
0 0 0 00000100 00000005 00000007 00000000 00000000 01 0 00000100 01 0000000c 00000104 0 0
0 1 0 00000104 00000005 00000007 00000000 00000000 02 0 00000104 02 fffffffe 00000108 0 0
0 2 0 00000108 f0f0f0f0 ff00ff00 00000000 00000000 03 0 00000108 03 f000f000 0000010c 0 0
0 3 0 0000010c f0f0f0f0 0f0f0000 00000000 00000000 04 0 0000010c 04 fffff0f0 00000110 0 0
0 4 0 00000110 ffff0000 0ff00ff0 00000000 00000000 05 0 00000110 05 f00f0ff0 00000114 0 0
0 5 0 00000114 80000011 00000024 00000000 00000000 06 0 00000114 06 00000110 00000118 0 0
0 6 0 00000118 80000010 00000004 00000000 00000000 07 0 00000118 07 08000001 0000011c 0 0
0 7 0 0000011c 80000010 00000004 00000000 00000000 08 0 0000011c 08 f8000001 00000120 0 0
0 8 0 00000120 ffffffff 00000001 00000000 00000000 09 0 00000120 09 00000001 00000124 0 0
0 9 0 00000124 ffffffff 00000001 00000000 00000000 0a 0 00000124 0a 00000000 00000128 0 0
0 a 0 00000128 00000007 00000007 00000000 00000000 0b 0 00000128 0b 00000001 0000012c 0 0
0 b 0 0000012c 00000008 00000007 00000000 00000000 0c 0 0000012c 0c 00000000 00000130 0 0
0 0 0 00000130 00000001 00000002 00000000 00000000 00 1 00000130 00 00000000 00000134 0 1
1 1 0 00000134 00000009 00000009 00000020 00000134 00 0 00000134 00 00000000 00000154 1 0
1 1 0 00000138 00000009 00000008 00000020 00000138 00 0 00000138 00 00000000 0000013c 0 0
1 8 0 0000013c fffffffe 00000003 fffffff0 0000013c 00 0 0000013c 00 00000000 0000012c 1 0
2 0 0 00000140 00000000 00000000 00000008 00000200 01 0 00000140 01 00000144 00000208 1 0
4 0 0 00000144 00000000 deadbeef 00000004 00000040 00 0 00000144 00 00000000 00000148 0 0
3 0 0 00000148 00000000 00000000 00000004 00000040 0d 0 00000148 0d deadbeef 0000014c 0 0
3 0 0 0000014c 00000000 00000000 00000000 00000080 0e 0 0000014c 0e 00000000 00000150 0 0
5 0 0 00000150 00000400 00000000 00000305 00000000 01 0 00000150 01 00000000 00000154 0 0
5 0 1 00000154 00000003 00000000 00000305 00000000 02 0 00000154 02 00000400 00000158 0 0
5 0 2 00000158 00000003 00000000 00000305 00000000 03 0 00000158 03 00000403 0000015c 0 0
5 0 1 0000015c 00000000 00000000 00000305 00000000 04 0 0000015c 04 00000400 00000160 0 0
5 0 0 00000160 00000088 00000000 00000300 00000000 05 0 00000160 05 00000000 00000164 0 0
5 0 2 00000164 00000008 00000000 00000300 00000000 06 0 00000164 06 00000088 00000168 0 0
5 0 1 00000168 00000000 00000000 00000300 00000000 07 0 00000168 07 00000080 0000016c 0 0
6 0 0 0000016c 00000000 00000000 00000000 00000000 00 0 0000016c 00 00000000 00000400 1 0
5 0 1 00000400 00000000 00000000 00000341 00000000 08 0 00000400 08 0000016c 00000404 0 0
5 0 1 00000404 00000000 00000000 00000342 00000000 09 0 00000404 09 0000000b 00000408 0 0
5 0 0 00000408 00000170 00000000 00000341 00000000 00 0 00000408 00 00000000 0000040c 0 0
7 0 0 0000040c 00000000 00000000 00000000 00000000 00 0 0000040c 00 00000000 00000170 1 0
5 0 1 00000170 00000000 00000000 00000300 00000000 0a 0 00000170 0a 00000088 00000174 0 0

// ==== rv_exu.f ====
src/exu_pkg.sv
src/exu_alu.sv
src/exu_csr.sv
src/exu_stage.sv
src/exu_dmem.sv
src/exu_top.sv
dv/exu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exu_tb -f rv_exu.f -o exu_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/exu_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation returned an error, see sim.log"
  exit 1
fi

if grep -q "all tests passed" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL, see sim.log"
  exit 1
fi
